// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := memoryGameTb
FILELIST := filelist.f
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(wildcard rtl/*.sv rtl/*.svh verif/*.sv)
FAIL_MSG := FAIL: see errors above
PASS_MSG := PASS: all tests

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) +verilator+error+limit+1000 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: filelist.f
+incdir+rtl
rtl/memoryGamePkg.sv
rtl/buttonDecoder.sv
rtl/gameControl.sv
rtl/gameDatapath.sv
rtl/gameResult.sv
rtl/memoryGame.sv
verif/memoryGame_asserts.sv
verif/memoryGameTb.sv

// File: rtl/buttonDecoder.sv
// Button front end that synchronizes the buttons and turns a new single press into a color pulse
module buttonDecoder (
    input  logic                  clock,
    input  logic                  reset,
    input  memoryGamePkg::color_t buttons,
    output logic                  pressValid,
    output memoryGamePkg::color_t pressColor
);

    import memoryGamePkg::*;

    color_t syncFirst;
    color_t syncSecond;
    color_t previous;
    logic   newPress;

    // --------------------
    // Synchronizer and edge flop
    // --------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            syncFirst  <= '0;
            syncSecond <= '0;
            previous   <= '0;
        end else begin
            syncFirst  <= buttons;
            syncSecond <= syncFirst;
            previous   <= syncSecond;
        end
    end

    // From all released to exactly one button down
    assign newPress = (previous == '0) && $onehot(syncSecond);

    // Pulse output
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pressValid <= 1'b0;
        end else begin
            pressValid <= newPress;
        end
    end

    // Color of the last accepted press held until the next one
    always_ff @(posedge clock) begin
        if (newPress) begin
            pressColor <= syncSecond;
        end
    end

endmodule

// File: rtl/gameControl.sv
// Moore FSM that drives the memory game datapath strobes from the current state
module gameControl (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       start,
    input  logic                       pressValid,
    input  memoryGamePkg::statusBus_t  status,
    output memoryGamePkg::controlBus_t control,
    output memoryGamePkg::gameState_t  state
);

    import memoryGamePkg::*;

    gameState_t nextState;

    // --------------------
    // State register
    // --------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        nextState = idle;
        case (state)
            idle:       nextState = start ? loadLevels : idle;
            loadLevels: nextState = roundStart;
            roundStart: nextState = show;
            show:       nextState = showWait;
            showWait: begin
                if (!status.showDone) begin
                    nextState = showWait;
                end else if (status.addressAtRound) begin
                    // Last entry of this round has been shown
                    nextState = playStart;
                end else begin
                    nextState = showNext;
                end
            end
            showNext:   nextState = show;
            playStart:  nextState = playWait;
            playWait: begin
                if (status.playExpired) begin
                    nextState = timedOut;
                end else if (pressValid) begin
                    nextState = capture;
                end else begin
                    nextState = playWait;
                end
            end
            capture:    nextState = compare;
            compare: begin
                if (!status.playCorrect) begin
                    nextState = lost;
                end else if (!status.addressAtRound) begin
                    nextState = nextPlay;
                end else if (status.lastRound) begin
                    nextState = won;
                end else begin
                    nextState = nextRound;
                end
            end
            nextPlay:   nextState = playWait;
            nextRound:  nextState = roundStart;
            won:        nextState = start ? loadLevels : won;
            lost:       nextState = start ? loadLevels : lost;
            timedOut:   nextState = start ? loadLevels : timedOut;
            default:    nextState = idle;
        endcase
    end

    // --------------------
    // Moore outputs
    // --------------------
    always_comb begin
        control = '0;
        case (state)
            idle: begin
                control.clearPlayReg = 1'b1;
            end
            loadLevels: begin
                control.clearRound   = 1'b1;
                control.clearPlay    = 1'b1;
                control.clearPlayReg = 1'b1;
                control.loadLevels   = 1'b1;
            end
            roundStart: begin
                control.clearAddress = 1'b1;
            end
            show: begin
                control.clearShow = 1'b1;
                control.showing   = 1'b1;
            end
            showWait: begin
                control.countShow = 1'b1;
                control.showing   = 1'b1;
            end
            // Dark gap between two shown colors
            showNext: begin
                control.countAddress = 1'b1;
            end
            playStart: begin
                control.clearAddress = 1'b1;
                control.clearPlay    = 1'b1;
            end
            playWait: begin
                control.countPlay = 1'b1;
            end
            capture: begin
                control.capturePlay = 1'b1;
            end
            nextPlay: begin
                control.countAddress = 1'b1;
                control.clearPlay    = 1'b1;
            end
            nextRound: begin
                control.countRound = 1'b1;
            end
            default: begin
                control = '0;
            end
        endcase
    end

endmodule

// File: rtl/gameDatapath.sv
// Memory game datapath with counters, timers, sequence table and press comparator
`include "memoryGame_cfg.svh"

module gameDatapath (
    input  logic                       clock,
    input  logic                       reset,
    input  memoryGamePkg::controlBus_t control,
    input  memoryGamePkg::color_t      pressColor,
    input  logic                       levelTime,
    input  logic                       levelLength,
    output memoryGamePkg::statusBus_t  status,
    output memoryGamePkg::color_t      shownColor,
    output logic [`ADDR_WIDTH-1:0]     roundIndex
);

    import memoryGamePkg::*;

    localparam int AW = `ADDR_WIDTH;
    localparam int SW = $clog2(`SHOW_TICKS);
    localparam int PW = $clog2(`PLAY_TICKS_LONG);

    logic [AW-1:0] address;
    logic [AW-1:0] round;
    logic [SW-1:0] showTimer;
    logic [PW-1:0] playTimer;
    logic          levelTimeReg;
    logic          levelLengthReg;
    color_t        playReg;
    color_t        expected;
    logic [AW-1:0] roundLimit;
    logic [PW-1:0] playLimit;

    // Color at address a is one-hot of (3a + 1) mod 4
    function automatic color_t colorAt(input logic [AW-1:0] a);
        logic [1:0] index;
        index = a[1:0] * 2'd3 + 2'd1;
        colorAt = color_t'(4'b0001 << index);
    endfunction

    // --------------------
    // Counters and timers
    // --------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            address   <= '0;
            round     <= '0;
            showTimer <= '0;
            playTimer <= '0;
        end else begin
            if (control.clearAddress) begin
                address <= '0;
            end else if (control.countAddress) begin
                address <= address + 1'b1;
            end

            if (control.clearRound) begin
                round <= '0;
            end else if (control.countRound) begin
                round <= round + 1'b1;
            end

            if (control.clearShow) begin
                showTimer <= '0;
            end else if (control.countShow) begin
                showTimer <= showTimer + 1'b1;
            end

            if (control.clearPlay) begin
                playTimer <= '0;
            end else if (control.countPlay) begin
                playTimer <= playTimer + 1'b1;
            end
        end
    end

    // Levels sampled once per game
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            levelTimeReg   <= 1'b0;
            levelLengthReg <= 1'b0;
        end else if (control.loadLevels) begin
            levelTimeReg   <= levelTime;
            levelLengthReg <= levelLength;
        end
    end

    // Captured press
    always_ff @(posedge clock) begin
        if (control.clearPlayReg) begin
            playReg <= '0;
        end else if (control.capturePlay) begin
            playReg <= pressColor;
        end
    end

    // --------------------
    // Status
    // --------------------
    assign expected   = colorAt(address);
    assign roundLimit = levelLengthReg ? AW'(`ROUNDS_LONG - 1) : AW'(`ROUNDS_SHORT - 1);
    assign playLimit  = levelTimeReg ? PW'(`PLAY_TICKS_LONG - 1) : PW'(`PLAY_TICKS_SHORT - 1);

    assign status.addressAtRound = (address == round);
    assign status.showDone       = (showTimer == SW'(`SHOW_TICKS - 1));
    assign status.playCorrect    = (playReg == expected);
    assign status.lastRound      = (round == roundLimit);
    assign status.playExpired    = (playTimer == playLimit);
    assign status.addressAtZero  = (address == '0);

    assign shownColor = control.showing ? expected : '0;
    assign roundIndex = round;

endmodule

// File: rtl/gameResult.sv
// Result stage that latches outcome and score at game end and drives the lights
`include "memoryGame_cfg.svh"

module gameResult (
    input  logic                      clock,
    input  logic                      reset,
    input  memoryGamePkg::gameState_t state,
    input  memoryGamePkg::color_t     shownColor,
    input  logic [`ADDR_WIDTH-1:0]    roundIndex,
    output memoryGamePkg::color_t     leds,
    output logic                      playerTurn,
    output logic                      won,
    output logic                      lost,
    output logic                      timedOut,
    output logic                      done,
    output logic [`ADDR_WIDTH:0]      score
);

    import memoryGamePkg::*;

    outcome_t outcome;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            outcome <= none;
            score   <= '0;
            leds    <= '0;
        end else begin
            leds <= shownColor;
            case (state)
                memoryGamePkg::loadLevels: begin
                    outcome <= none;
                    score   <= '0;
                end
                // A win also completes the current round
                memoryGamePkg::won: begin
                    outcome <= win;
                    score   <= {1'b0, roundIndex} + 1'b1;
                end
                memoryGamePkg::lost: begin
                    outcome <= loss;
                    score   <= {1'b0, roundIndex};
                end
                memoryGamePkg::timedOut: begin
                    outcome <= timeout;
                    score   <= {1'b0, roundIndex};
                end
                default: begin
                    outcome <= outcome;
                end
            endcase
        end
    end

    assign playerTurn = (state == memoryGamePkg::playWait);
    assign won        = (outcome == win);
    assign lost       = (outcome == loss);
    assign timedOut   = (outcome == timeout);
    assign done       = (outcome != none);

endmodule

// File: rtl/memoryGame.sv
// Top level of the memory game that wires decoder, control unit, datapath and result stage
`include "memoryGame_cfg.svh"

module memoryGame (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      start,
    input  memoryGamePkg::color_t     buttons,
    input  logic                      levelTime,
    input  logic                      levelLength,
    output memoryGamePkg::color_t     leds,
    output logic                      playerTurn,
    output logic                      won,
    output logic                      lost,
    output logic                      timedOut,
    output logic                      done,
    output logic [`ADDR_WIDTH:0]      score,
    output memoryGamePkg::gameState_t debugState
);

    import memoryGamePkg::*;

    logic                   pressValid;
    color_t                 pressColor;
    controlBus_t            control;
    statusBus_t             status;
    gameState_t             state;
    color_t                 shownColor;
    logic [`ADDR_WIDTH-1:0] roundIndex;

    // --------------------
    // Decode
    // --------------------
    buttonDecoder i_buttonDecoder (
        .clock      (clock),
        .reset      (reset),
        .buttons    (buttons),
        .pressValid (pressValid),
        .pressColor (pressColor)
    );

    // --------------------
    // Execute
    // --------------------
    gameControl i_gameControl (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .pressValid (pressValid),
        .status     (status),
        .control    (control),
        .state      (state)
    );

    gameDatapath i_gameDatapath (
        .clock       (clock),
        .reset       (reset),
        .control     (control),
        .pressColor  (pressColor),
        .levelTime   (levelTime),
        .levelLength (levelLength),
        .status      (status),
        .shownColor  (shownColor),
        .roundIndex  (roundIndex)
    );

    // --------------------
    // Result
    // --------------------
    gameResult i_gameResult (
        .clock      (clock),
        .reset      (reset),
        .state      (state),
        .shownColor (shownColor),
        .roundIndex (roundIndex),
        .leds       (leds),
        .playerTurn (playerTurn),
        .won        (won),
        .lost       (lost),
        .timedOut   (timedOut),
        .done       (done),
        .score      (score)
    );

    assign debugState = state;

endmodule

// File: rtl/memoryGamePkg.sv
// Shared types of the memory game for colors, FSM states and the control and status buses
package memoryGamePkg;

    // One-hot button or light color where zero means none
    typedef logic [3:0] color_t;

    // FSM states of the control unit
    typedef enum logic [3:0] {
        idle       = 4'h0,
        loadLevels = 4'h1,
        roundStart = 4'h2,
        show       = 4'h3,
        showWait   = 4'h4,
        showNext   = 4'h5,
        playStart  = 4'h6,
        playWait   = 4'h7,
        capture    = 4'h8,
        compare    = 4'h9,
        won        = 4'hA,
        nextPlay   = 4'hB,
        nextRound  = 4'hC,
        lost       = 4'hE,
        timedOut   = 4'hF
    } gameState_t;

    // Strobes from the control unit to the datapath
    typedef struct packed {
        logic clearAddress;
        logic countAddress;
        logic clearShow;
        logic countShow;
        logic clearRound;
        logic countRound;
        logic clearPlay;
        logic countPlay;
        logic capturePlay;
        logic clearPlayReg;
        logic loadLevels;
        logic showing;
    } controlBus_t;

    // Conditions from the datapath back to the control unit
    typedef struct packed {
        logic addressAtRound;
        logic showDone;
        logic playCorrect;
        logic lastRound;
        logic playExpired;
        logic addressAtZero;
    } statusBus_t;

    typedef enum logic [1:0] {
        none    = 2'd0,
        win     = 2'd1,
        loss    = 2'd2,
        timeout = 2'd3
    } outcome_t;

endpackage

// File: rtl/memoryGame_cfg.svh
// Width, round-count and timer constants that the memory game RTL includes
`ifndef MEMORYGAME_CFG_SVH
`define MEMORYGAME_CFG_SVH

// --------------------
// Sequence and rounds
// --------------------
`define ADDR_WIDTH 4
`define ROUNDS_LONG 16
`define ROUNDS_SHORT 8

// --------------------
// Timers in clock cycles
// --------------------
// Each shown color stays lit this long
`define SHOW_TICKS 4

// Time allowed per press
`define PLAY_TICKS_LONG 64
`define PLAY_TICKS_SHORT 32

`endif

// File: verif/memoryGameTb.sv
// Testbench that plays, misplays and times out memory games and reports each test
`include "memoryGame_cfg.svh"

module memoryGameTb;

    import memoryGamePkg::*;

    localparam int WAIT_LIMIT = 500;

    logic                   clock;
    logic                   reset;
    logic                   start;
    color_t                 buttons;
    logic                   levelTime;
    logic                   levelLength;
    color_t                 leds;
    logic                   playerTurn;
    logic                   won;
    logic                   lost;
    logic                   timedOut;
    logic                   done;
    logic [`ADDR_WIDTH:0]   score;
    gameState_t             debugState;

    integer seed;
    logic   hung;
    int     errors;
    int     testsRun;
    int     testsFailed;
    int     failuresSeen;

    memoryGame i_memoryGame (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .buttons     (buttons),
        .levelTime   (levelTime),
        .levelLength (levelLength),
        .leds        (leds),
        .playerTurn  (playerTurn),
        .won         (won),
        .lost        (lost),
        .timedOut    (timedOut),
        .done        (done),
        .score       (score),
        .debugState  (debugState)
    );

    bind memoryGame memoryGame_asserts i_asserts (
        .clock       (clock),
        .reset       (reset),
        .levelLength (levelLength),
        .leds        (leds),
        .playerTurn  (playerTurn),
        .won         (won),
        .lost        (lost),
        .timedOut    (timedOut),
        .done        (done),
        .score       (score),
        .debugState  (debugState)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // --------------------
    // Helpers
    // --------------------
    // Color at entry a is one-hot of (3a + 1) mod 4
    function automatic color_t tableColor(input int a);
        case (a % 4)
            0:       return 4'b0010;
            1:       return 4'b0001;
            2:       return 4'b1000;
            default: return 4'b0100;
        endcase
    endfunction

    // Rotate the right color by 1 to 3 places
    function automatic color_t wrongColor(input color_t right);
        int         offset;
        logic [7:0] doubled;
        offset  = 1 + ($unsigned($random(seed)) % 3);
        doubled = {right, right} >> offset;
        return doubled[3:0];
    endfunction

    task automatic waitForTurn();
        int count;
        count = 0;
        @(negedge clock);
        while (!playerTurn && count < WAIT_LIMIT && !hung) begin
            @(negedge clock);
            count++;
        end
        if (!playerTurn && !hung) begin
            $display("timed out waiting for playerTurn at %0t", $time);
            hung = 1'b1;
        end
    endtask

    task automatic waitForDone(input logic level);
        int count;
        count = 0;
        @(negedge clock);
        while (done !== level && count < WAIT_LIMIT && !hung) begin
            @(negedge clock);
            count++;
        end
        if (done !== level && !hung) begin
            $display("timed out waiting for done to become %b at %0t", level, $time);
            hung = 1'b1;
        end
    endtask

    // Hold for 5 cycles, then release for 5
    task automatic pressButton(input color_t color);
        @(posedge clock);
        buttons <= color;
        repeat (5) @(posedge clock);
        buttons <= '0;
        repeat (5) @(posedge clock);
    endtask

    task automatic startGame(input logic timeLevel, input logic lengthLevel);
        @(posedge clock);
        levelTime   <= timeLevel;
        levelLength <= lengthLevel;
        start       <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
        waitForDone(1'b0);
    endtask

    // Wrong press on the last entry of round wrongRound unless it is -1
    task automatic playGame(input int rounds, input int wrongRound);
        color_t color;
        logic   stop;
        stop = 1'b0;
        for (int r = 0; r < rounds && !stop; r++) begin
            for (int a = 0; a <= r && !stop; a++) begin
                waitForTurn();
                if (hung) begin
                    stop = 1'b1;
                end else begin
                    color = tableColor(a);
                    if (r == wrongRound && a == r) begin
                        color = wrongColor(color);
                        stop  = 1'b1;
                    end
                    pressButton(color);
                end
            end
        end
    endtask

    // Expected flags in the order won, lost, timedOut
    task automatic checkOutcome(input logic [2:0] expected);
        if ({won, lost, timedOut} !== expected) begin
            $display("Error at %0t: outcome %b, expected %b", $time, {won, lost, timedOut},
                expected);
            errors++;
        end
    endtask

    task automatic reportTest(input string name);
        int failuresNow;
        repeat (2) @(posedge clock);
        failuresNow = i_memoryGame.i_asserts.failures + errors;
        testsRun++;
        if (hung || failuresNow != failuresSeen) begin
            testsFailed++;
            $display("test %0d %s: failed", testsRun, name);
        end else begin
            $display("test %0d %s: passed", testsRun, name);
        end
        failuresSeen = failuresNow;
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        seed         = 32'h9baf;
        reset        = 1'b1;
        start        = 1'b0;
        buttons      = '0;
        levelTime    = 1'b0;
        levelLength  = 1'b0;
        hung         = 1'b0;
        errors       = 0;
        testsRun     = 0;
        testsFailed  = 0;
        failuresSeen = 0;
        repeat (5) @(posedge clock);
        reset <= 1'b0;

        repeat (2) @(posedge clock);
        reportTest("reset values");

        startGame(1'b1, 1'b0);
        playGame(`ROUNDS_SHORT, -1);
        waitForDone(1'b1);
        checkOutcome(3'b100);
        reportTest("short game won");

        startGame(1'b1, 1'b1);
        playGame(`ROUNDS_LONG, -1);
        waitForDone(1'b1);
        checkOutcome(3'b100);
        reportTest("long game won");

        startGame(1'b1, 1'b0);
        playGame(`ROUNDS_SHORT, 2);
        waitForDone(1'b1);
        checkOutcome(3'b010);
        reportTest("wrong color in round 3");

        // No press at all, then a fresh game from the end state
        startGame(1'b0, 1'b0);
        waitForDone(1'b1);
        checkOutcome(3'b001);
        startGame(1'b0, 1'b0);
        playGame(`ROUNDS_SHORT, -1);
        waitForDone(1'b1);
        checkOutcome(3'b100);
        reportTest("timeout then restart");

        $display("tests run %0d, passed %0d, failed %0d", testsRun, testsRun - testsFailed,
            testsFailed);
        if (testsFailed == 0 && !hung) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: verif/memoryGame_asserts.sv
// Concurrent checks on outcome, score and shown colors that bind to the memory game top level
`include "memoryGame_cfg.svh"

module memoryGame_asserts (
    input logic                      clock,
    input logic                      reset,
    input logic                      levelLength,
    input memoryGamePkg::color_t     leds,
    input logic                      playerTurn,
    input logic                      won,
    input logic                      lost,
    input logic                      timedOut,
    input logic                      done,
    input logic [`ADDR_WIDTH:0]      score,
    input memoryGamePkg::gameState_t debugState
);

    import memoryGamePkg::*;

    localparam int CW = `ADDR_WIDTH + 1;

    int            failures = 0;
    logic          lengthLevel;
    logic [CW-1:0] roundsPlayed;
    logic [CW-1:0] showIndex;
    logic          turnSeen;
    logic          turnBefore;
    color_t        ledsBefore;
    logic [CW-1:0] roundsToWin;
    logic          endState;

    // Sequence entries light indices 1, 0, 3, 2 and then repeat
    function automatic color_t tableColor(input logic [CW-1:0] a);
        case (a[1:0])
            2'd0:    return 4'b0010;
            2'd1:    return 4'b0001;
            2'd2:    return 4'b1000;
            default: return 4'b0100;
        endcase
    endfunction

    // --------------------
    // Round and entry tracking
    // --------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            lengthLevel  <= 1'b0;
            roundsPlayed <= '0;
            showIndex    <= '0;
            turnSeen     <= 1'b0;
            turnBefore   <= 1'b0;
            ledsBefore   <= '0;
        end else begin
            turnBefore <= playerTurn;
            ledsBefore <= leds;
            if (debugState == loadLevels) begin
                lengthLevel  <= levelLength;
                roundsPlayed <= '0;
                showIndex    <= '0;
                turnSeen     <= 1'b0;
            end else begin
                // Lights on again means a new round is being shown
                if (leds != '0) begin
                    turnSeen <= 1'b0;
                end
                if (playerTurn && !turnBefore && !turnSeen) begin
                    roundsPlayed <= roundsPlayed + 1'b1;
                    turnSeen     <= 1'b1;
                    showIndex    <= '0;
                end else if (ledsBefore != '0 && leds == '0) begin
                    showIndex <= showIndex + 1'b1;
                end
            end
        end
    end

    assign roundsToWin = lengthLevel ? CW'(`ROUNDS_LONG) : CW'(`ROUNDS_SHORT);

    // Game over states of the FSM
    assign endState = (debugState == memoryGamePkg::won) || (debugState == memoryGamePkg::lost)
        || (debugState == memoryGamePkg::timedOut);

    // --------------------
    // Checks
    // --------------------
    assert property (@(posedge clock) $fell(reset) |-> (leds == '0) && !playerTurn && !won
            && !lost && !timedOut && !done && (debugState == idle))
    else begin
        $error("Error at %0t: outputs not cleared after reset", $time);
        failures++;
    end

    assert property (@(posedge clock) disable iff (reset)
            $rose(won) |-> (score == roundsToWin) && (score == roundsPlayed))
    else begin
        $error("Error at %0t: score %0d on win, expected %0d", $time, score, roundsToWin);
        failures++;
    end

    // Current round is not completed on a loss or timeout
    assert property (@(posedge clock) disable iff (reset)
            ($rose(lost) || $rose(timedOut)) |-> (score == roundsPlayed - 1'b1))
    else begin
        $error("Error at %0t: score %0d at game end, expected %0d", $time, score,
            roundsPlayed - 1'b1);
        failures++;
    end

    // Outcome is latched one edge after an end state is entered
    assert property (@(posedge clock) disable iff (reset) done == $past(endState))
    else begin
        $error("Error at %0t: done %b does not follow the end state", $time, done);
        failures++;
    end

    assert property (@(posedge clock) disable iff (reset)
            (leds != '0) |-> (leds == tableColor(showIndex)))
    else begin
        $error("Error at %0t: leds %b at entry %0d, expected %b", $time, leds, showIndex,
            tableColor(showIndex));
        failures++;
    end

endmodule
